//--- rtl/isq_pkg.sv
package isq_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int PREG_W    = 6;   // 64 physical registers.
    localparam int ROB_IDX_W = 5;   // rob index without wrap bit.
    localparam int IMM_W     = 32;

    // ============================================================
    // storage types
    // ============================================================
    typedef logic [PREG_W-1:0]  preg_t;
    typedef logic [ROB_IDX_W:0] robid_t;   // msb is the wrap bit.
    typedef logic [IMM_W-1:0]   imm_t;

    // alu opcodes, stored and forwarded only.
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7
    } alu_op_e;

endpackage

//--- rtl/isq_alloc.sv
`timescale 1ns/1ps

module isq_alloc #(
    parameter int DEPTH = 8
) (
    input  logic             enq_valid,
    input  logic [DEPTH-1:0] slot_valid,
    output logic [DEPTH-1:0] slot_wren,
    output logic             can_alloc
);

    // ============================================================
    // free slot search
    // ============================================================
    logic [DEPTH-1:0] free_vec;
    logic [DEPTH-1:0] first_free_oh;
    logic             found;

    assign free_vec = ~slot_valid;

    // priority finder, lowest index wins.
    always_comb begin
        first_free_oh = '0;
        found         = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (free_vec[i] && !found) begin
                first_free_oh[i] = 1'b1;
                found            = 1'b1;
            end
        end
    end

    // ============================================================
    // accept
    // ============================================================
    assign can_alloc = found;   // level back to dispatch.

    // one-hot is empty when full, so a blocked enqueue writes nothing.
    assign slot_wren = first_free_oh & {DEPTH{enq_valid}};

endmodule

//--- rtl/isq_entry.sv
`timescale 1ns/1ps

module isq_entry (
    input  logic             clock,
    input  logic             rst,
    input  logic             wren,
    input  isq_pkg::alu_op_e enq_alu_op,
    input  isq_pkg::imm_t    enq_imm,
    input  logic             enq_src1_is_reg,
    input  logic             enq_src2_is_reg,
    input  isq_pkg::preg_t   enq_prs1,
    input  isq_pkg::preg_t   enq_prs2,
    input  isq_pkg::preg_t   enq_prd,
    input  logic             enq_src1_state,
    input  logic             enq_src2_state,
    input  isq_pkg::robid_t  enq_robid,
    input  logic             wb0_valid,
    input  logic             wb0_need_to_wb,
    input  isq_pkg::preg_t   wb0_prd,
    input  logic             wb1_valid,
    input  logic             wb1_need_to_wb,
    input  isq_pkg::preg_t   wb1_prd,
    input  logic             flush_valid,
    input  isq_pkg::robid_t  flush_robid,
    input  logic             issuing,
    output logic             valid,
    output logic             ready_to_go,
    output isq_pkg::alu_op_e alu_op,
    output isq_pkg::imm_t    imm,
    output isq_pkg::preg_t   prs1,
    output isq_pkg::preg_t   prs2,
    output isq_pkg::preg_t   prd,
    output isq_pkg::robid_t  robid,
    output logic             src1_is_reg,
    output logic             src2_is_reg
);

    logic src1_state;
    logic src2_state;
    logic wb0_hit;
    logic wb1_hit;
    logic wake_src1;
    logic wake_src2;
    logic flush_hit;

    // ============================================================
    // wakeup
    // ============================================================
    assign wb0_hit = wb0_valid & wb0_need_to_wb;
    assign wb1_hit = wb1_valid & wb1_need_to_wb;

    assign wake_src1 = src1_is_reg &
                       ((wb0_hit & (wb0_prd == prs1)) | (wb1_hit & (wb1_prd == prs1)));
    assign wake_src2 = src2_is_reg &
                       ((wb0_hit & (wb0_prd == prs2)) | (wb1_hit & (wb1_prd == prs2)));

    // ============================================================
    // flush age compare
    // ============================================================
    // younger when wrap bits differ xor flush index is below ours.
    assign flush_hit = flush_valid & valid &
        ((flush_robid[isq_pkg::ROB_IDX_W] ^ robid[isq_pkg::ROB_IDX_W]) ^
         (flush_robid[isq_pkg::ROB_IDX_W-1:0] < robid[isq_pkg::ROB_IDX_W-1:0]));

    // control state.
    always_ff @(posedge clock) begin
        if (rst) begin
            valid      <= 1'b0;
            src1_state <= 1'b0;
            src2_state <= 1'b0;
        end else if (wren) begin
            valid      <= 1'b1;
            src1_state <= enq_src1_state;   // same-cycle writeback is missed.
            src2_state <= enq_src2_state;
        end else begin
            if (issuing || flush_hit) begin
                valid <= 1'b0;
            end
            if (wake_src1) begin
                src1_state <= 1'b1;
            end
            if (wake_src2) begin
                src2_state <= 1'b1;
            end
        end
    end

    // payload.
    always_ff @(posedge clock) begin
        if (wren) begin
            alu_op      <= enq_alu_op;
            imm         <= enq_imm;
            prs1        <= enq_prs1;
            prs2        <= enq_prs2;
            prd         <= enq_prd;
            robid       <= enq_robid;
            src1_is_reg <= enq_src1_is_reg;
            src2_is_reg <= enq_src2_is_reg;
        end
    end

    // a non-register source never waits.
    assign ready_to_go = valid & (src1_state | ~src1_is_reg) & (src2_state | ~src2_is_reg);

endmodule

//--- rtl/isq_age_select.sv
`timescale 1ns/1ps

module isq_age_select #(
    parameter int DEPTH = 8
) (
    input  logic             clock,
    input  logic             rst,
    input  logic [DEPTH-1:0] slot_wren,
    input  logic [DEPTH-1:0] slot_valid,
    input  logic [DEPTH-1:0] slot_ready,
    input  logic             issue_ready,
    input  isq_pkg::alu_op_e slot_alu_op [DEPTH],
    input  isq_pkg::imm_t    slot_imm [DEPTH],
    input  isq_pkg::preg_t   slot_prs1 [DEPTH],
    input  isq_pkg::preg_t   slot_prs2 [DEPTH],
    input  isq_pkg::preg_t   slot_prd [DEPTH],
    input  isq_pkg::robid_t  slot_robid [DEPTH],
    input  logic [DEPTH-1:0] slot_src1_is_reg,
    input  logic [DEPTH-1:0] slot_src2_is_reg,
    output logic [DEPTH-1:0] issuing,
    output logic             issue_valid,
    output isq_pkg::alu_op_e issue_alu_op,
    output isq_pkg::imm_t    issue_imm,
    output isq_pkg::preg_t   issue_prs1,
    output isq_pkg::preg_t   issue_prs2,
    output isq_pkg::preg_t   issue_prd,
    output isq_pkg::robid_t  issue_robid,
    output logic             issue_src1_is_reg,
    output logic             issue_src2_is_reg
);

    // older[j][i] set means slot i is older than slot j.
    logic [DEPTH-1:0] older [DEPTH];
    logic [DEPTH-1:0] sel_oh;
    logic [$bits(isq_pkg::alu_op_e)-1:0] op_mux;

    // ============================================================
    // age matrix
    // ============================================================
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int j = 0; j < DEPTH; j++) begin
                older[j] <= '0;
            end
        end else begin
            for (int j = 0; j < DEPTH; j++) begin
                if (slot_wren[j]) begin
                    older[j] <= slot_valid & ~issuing;   // all survivors are older.
                end else begin
                    older[j] <= older[j] & ~slot_wren;   // new slot is older than none.
                end
            end
        end
    end

    // oldest ready slot: no ready slot ahead of it.
    always_comb begin
        for (int j = 0; j < DEPTH; j++) begin
            sel_oh[j] = slot_ready[j] & ~(|(older[j] & slot_ready));
        end
    end

    assign issue_valid = |slot_ready;
    assign issuing     = sel_oh & {DEPTH{issue_valid & issue_ready}};

    // ============================================================
    // issue payload mux
    // ============================================================
    always_comb begin
        op_mux            = '0;
        issue_imm         = '0;
        issue_prs1        = '0;
        issue_prs2        = '0;
        issue_prd         = '0;
        issue_robid       = '0;
        issue_src1_is_reg = 1'b0;
        issue_src2_is_reg = 1'b0;
        for (int j = 0; j < DEPTH; j++) begin
            if (sel_oh[j]) begin
                op_mux            = op_mux | slot_alu_op[j];
                issue_imm         = issue_imm | slot_imm[j];
                issue_prs1        = issue_prs1 | slot_prs1[j];
                issue_prs2        = issue_prs2 | slot_prs2[j];
                issue_prd         = issue_prd | slot_prd[j];
                issue_robid       = issue_robid | slot_robid[j];
                issue_src1_is_reg = issue_src1_is_reg | slot_src1_is_reg[j];
                issue_src2_is_reg = issue_src2_is_reg | slot_src2_is_reg[j];
            end
        end
    end

    assign issue_alu_op = isq_pkg::alu_op_e'(op_mux);

endmodule

//--- rtl/int_isq.sv
`timescale 1ns/1ps

module int_isq #(
    parameter int DEPTH = 8
) (
    input  logic             clock,
    input  logic             rst,
    input  logic             enq_valid,
    input  isq_pkg::alu_op_e enq_alu_op,
    input  isq_pkg::imm_t    enq_imm,
    input  logic             enq_src1_is_reg,
    input  logic             enq_src2_is_reg,
    input  isq_pkg::preg_t   enq_prs1,
    input  isq_pkg::preg_t   enq_prs2,
    input  isq_pkg::preg_t   enq_prd,
    input  logic             enq_src1_state,
    input  logic             enq_src2_state,
    input  isq_pkg::robid_t  enq_robid,
    input  logic             issue_ready,
    input  logic             wb0_valid,
    input  logic             wb0_need_to_wb,
    input  isq_pkg::preg_t   wb0_prd,
    input  logic             wb1_valid,
    input  logic             wb1_need_to_wb,
    input  isq_pkg::preg_t   wb1_prd,
    input  logic             flush_valid,
    input  isq_pkg::robid_t  flush_robid,
    output logic             can_alloc,
    output logic             issue_valid,
    output isq_pkg::alu_op_e issue_alu_op,
    output isq_pkg::imm_t    issue_imm,
    output isq_pkg::preg_t   issue_prs1,
    output isq_pkg::preg_t   issue_prs2,
    output isq_pkg::preg_t   issue_prd,
    output isq_pkg::robid_t  issue_robid,
    output logic             issue_src1_is_reg,
    output logic             issue_src2_is_reg
);

    logic [DEPTH-1:0] slot_wren;
    logic [DEPTH-1:0] slot_valid;
    logic [DEPTH-1:0] slot_ready;
    logic [DEPTH-1:0] issuing;
    logic [DEPTH-1:0] slot_src1_is_reg;
    logic [DEPTH-1:0] slot_src2_is_reg;
    isq_pkg::alu_op_e slot_alu_op [DEPTH];
    isq_pkg::imm_t    slot_imm [DEPTH];
    isq_pkg::preg_t   slot_prs1 [DEPTH];
    isq_pkg::preg_t   slot_prs2 [DEPTH];
    isq_pkg::preg_t   slot_prd [DEPTH];
    isq_pkg::robid_t  slot_robid [DEPTH];

    // ============================================================
    // allocation
    // ============================================================
    isq_alloc #(
        .DEPTH(DEPTH)
    ) u_isq_alloc (
        .enq_valid (enq_valid),
        .slot_valid(slot_valid),
        .slot_wren (slot_wren),
        .can_alloc (can_alloc)
    );

    // ============================================================
    // slot array
    // ============================================================
    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        isq_entry u_isq_entry (
            .clock          (clock),
            .rst            (rst),
            .wren           (slot_wren[i]),   // payload is broadcast, wren picks the slot.
            .enq_alu_op     (enq_alu_op),
            .enq_imm        (enq_imm),
            .enq_src1_is_reg(enq_src1_is_reg),
            .enq_src2_is_reg(enq_src2_is_reg),
            .enq_prs1       (enq_prs1),
            .enq_prs2       (enq_prs2),
            .enq_prd        (enq_prd),
            .enq_src1_state (enq_src1_state),
            .enq_src2_state (enq_src2_state),
            .enq_robid      (enq_robid),
            .wb0_valid      (wb0_valid),
            .wb0_need_to_wb (wb0_need_to_wb),
            .wb0_prd        (wb0_prd),
            .wb1_valid      (wb1_valid),
            .wb1_need_to_wb (wb1_need_to_wb),
            .wb1_prd        (wb1_prd),
            .flush_valid    (flush_valid),
            .flush_robid    (flush_robid),
            .issuing        (issuing[i]),
            .valid          (slot_valid[i]),
            .ready_to_go    (slot_ready[i]),
            .alu_op         (slot_alu_op[i]),
            .imm            (slot_imm[i]),
            .prs1           (slot_prs1[i]),
            .prs2           (slot_prs2[i]),
            .prd            (slot_prd[i]),
            .robid          (slot_robid[i]),
            .src1_is_reg    (slot_src1_is_reg[i]),
            .src2_is_reg    (slot_src2_is_reg[i])
        );
    end

    // ============================================================
    // oldest-ready select
    // ============================================================
    isq_age_select #(
        .DEPTH(DEPTH)
    ) u_isq_age_select (
        .clock            (clock),
        .rst              (rst),
        .slot_wren        (slot_wren),
        .slot_valid       (slot_valid),
        .slot_ready       (slot_ready),
        .issue_ready      (issue_ready),
        .slot_alu_op      (slot_alu_op),
        .slot_imm         (slot_imm),
        .slot_prs1        (slot_prs1),
        .slot_prs2        (slot_prs2),
        .slot_prd         (slot_prd),
        .slot_robid       (slot_robid),
        .slot_src1_is_reg (slot_src1_is_reg),
        .slot_src2_is_reg (slot_src2_is_reg),
        .issuing          (issuing),
        .issue_valid      (issue_valid),
        .issue_alu_op     (issue_alu_op),
        .issue_imm        (issue_imm),
        .issue_prs1       (issue_prs1),
        .issue_prs2       (issue_prs2),
        .issue_prd        (issue_prd),
        .issue_robid      (issue_robid),
        .issue_src1_is_reg(issue_src1_is_reg),
        .issue_src2_is_reg(issue_src2_is_reg)
    );

endmodule

//--- tb/int_isq_tb.sv
`timescale 1ns/1ps

module int_isq_tb;

    localparam int DEPTH          = 8;
    localparam int TIMEOUT_CYCLES = 5000;   // summed test lengths with margin.
    localparam int DRAIN_LIMIT    = 40;

    typedef struct packed {
        isq_pkg::alu_op_e op;
        isq_pkg::imm_t    imm;
        isq_pkg::preg_t   prs1;
        isq_pkg::preg_t   prs2;
        isq_pkg::preg_t   prd;
        isq_pkg::robid_t  robid;
        logic             s1reg;
        logic             s2reg;
        logic             s1rdy;
        logic             s2rdy;
    } entry_t;

    logic clock, rst, enq_valid, enq_src1_is_reg, enq_src2_is_reg, enq_src1_state;
    logic enq_src2_state, issue_ready, wb0_valid, wb0_need_to_wb, wb1_valid;
    logic wb1_need_to_wb, flush_valid, can_alloc, issue_valid, issue_src1_is_reg;
    logic issue_src2_is_reg;
    isq_pkg::alu_op_e enq_alu_op, issue_alu_op;
    isq_pkg::imm_t    enq_imm, issue_imm;
    isq_pkg::preg_t   enq_prs1, enq_prs2, enq_prd, wb0_prd, wb1_prd;
    isq_pkg::preg_t   issue_prs1, issue_prs2, issue_prd;
    isq_pkg::robid_t  enq_robid, flush_robid, issue_robid, next_robid;

    entry_t      model_q [$];   // oldest first.
    logic [15:0] lfsr_state = 16'd56;
    int          errors = 0;
    int          checks = 0;
    int          issued = 0;
    int          accepted = 0;
    int          accepted_start = 0;
    int          tests_run = 0;
    int          test_start = 0;

    int_isq #(.DEPTH(DEPTH)) u_int_isq (
        .clock(clock), .rst(rst), .enq_valid(enq_valid), .enq_alu_op(enq_alu_op),
        .enq_imm(enq_imm), .enq_src1_is_reg(enq_src1_is_reg),
        .enq_src2_is_reg(enq_src2_is_reg), .enq_prs1(enq_prs1), .enq_prs2(enq_prs2),
        .enq_prd(enq_prd), .enq_src1_state(enq_src1_state), .enq_src2_state(enq_src2_state),
        .enq_robid(enq_robid), .issue_ready(issue_ready), .wb0_valid(wb0_valid),
        .wb0_need_to_wb(wb0_need_to_wb), .wb0_prd(wb0_prd), .wb1_valid(wb1_valid),
        .wb1_need_to_wb(wb1_need_to_wb), .wb1_prd(wb1_prd), .flush_valid(flush_valid),
        .flush_robid(flush_robid), .can_alloc(can_alloc), .issue_valid(issue_valid),
        .issue_alu_op(issue_alu_op), .issue_imm(issue_imm), .issue_prs1(issue_prs1),
        .issue_prs2(issue_prs2), .issue_prd(issue_prd), .issue_robid(issue_robid),
        .issue_src1_is_reg(issue_src1_is_reg), .issue_src2_is_reg(issue_src2_is_reg)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // ============================================================
    // random source and reference model
    // ============================================================
    function automatic logic lfsr_step();
        logic lsb;
        lsb        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) lfsr_state = lfsr_state ^ 16'hB400;
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    // index of the oldest entry with both sources ready, -1 if none.
    function automatic int oldest_ready();
        for (int i = 0; i < model_q.size(); i++) begin
            if ((model_q[i].s1rdy || !model_q[i].s1reg) && (model_q[i].s2rdy || !model_q[i].s2reg))
                return i;
        end
        return -1;
    endfunction

    // younger means at most half the id ring ahead of the flush point.
    function automatic logic is_younger(input isq_pkg::robid_t f, input isq_pkg::robid_t e);
        isq_pkg::robid_t d;
        d = e - f;
        return (d != 6'd0) && (d <= isq_pkg::robid_t'(1 << isq_pkg::ROB_IDX_W));
    endfunction

    function automatic logic wakes(input logic is_reg, input isq_pkg::preg_t tag);
        return is_reg && ((wb0_valid && wb0_need_to_wb && wb0_prd == tag) ||
                          (wb1_valid && wb1_need_to_wb && wb1_prd == tag));
    endfunction

    // samples mid low phase, applies what the next rising edge will do.
    initial begin
        int     idx;
        logic   room;
        entry_t e;
        forever begin
            @(negedge clock);
            #1;
            if (!rst) begin
                idx    = oldest_ready();
                room   = model_q.size() < DEPTH;
                checks = checks + 1;
                if (issue_valid !== (idx >= 0)) begin
                    errors++;
                    $display("mismatch at %0t: issue_valid %b, model ready %b", $time,
                             issue_valid, idx >= 0);
                end
                if (can_alloc !== room) begin
                    errors++;
                    $display("mismatch at %0t: can_alloc %b, model room %b", $time,
                             can_alloc, room);
                end
                if (issue_valid && issue_ready && idx >= 0) begin
                    e = model_q[idx];
                    if ({issue_alu_op, issue_imm, issue_prs1, issue_prs2, issue_prd, issue_robid,
                         issue_src1_is_reg, issue_src2_is_reg} !==
                        {e.op, e.imm, e.prs1, e.prs2, e.prd, e.robid, e.s1reg, e.s2reg}) begin
                        errors++;
                        $display("mismatch at %0t: issued robid %h imm %h, expected robid %h imm %h",
                                 $time, issue_robid, issue_imm, e.robid, e.imm);
                    end
                    model_q.delete(idx);
                    issued++;
                end
                if (flush_valid) begin
                    for (int i = model_q.size() - 1; i >= 0; i--) begin
                        if (is_younger(flush_robid, model_q[i].robid)) model_q.delete(i);
                    end
                end
                for (int i = 0; i < model_q.size(); i++) begin   // new entry misses wakeup.
                    e = model_q[i];
                    if (wakes(e.s1reg, e.prs1)) e.s1rdy = 1'b1;
                    if (wakes(e.s2reg, e.prs2)) e.s2rdy = 1'b1;
                    model_q[i] = e;
                end
                if (enq_valid && room) begin
                    e.op    = enq_alu_op;
                    e.imm   = enq_imm;
                    e.prs1  = enq_prs1;
                    e.prs2  = enq_prs2;
                    e.prd   = enq_prd;
                    e.robid = enq_robid;
                    e.s1reg = enq_src1_is_reg;
                    e.s2reg = enq_src2_is_reg;
                    e.s1rdy = enq_src1_state;
                    e.s2rdy = enq_src2_state;
                    model_q.push_back(e);
                    accepted++;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // ============================================================
    // stimulus tasks
    // ============================================================
    task automatic enq(input logic s1reg, input isq_pkg::preg_t prs1, input logic st1,
                       input logic s2reg, input isq_pkg::preg_t prs2, input logic st2,
                       input isq_pkg::robid_t robid);
        enq_valid       = 1'b1;
        enq_alu_op      = isq_pkg::alu_op_e'({1'b0, robid[2:0]});
        enq_imm         = {8'hA5, 18'd0, robid};
        enq_src1_is_reg = s1reg;
        enq_prs1        = prs1;
        enq_src1_state  = st1;
        enq_src2_is_reg = s2reg;
        enq_prs2        = prs2;
        enq_src2_state  = st2;
        enq_prd         = robid ^ 6'h2A;
        enq_robid       = robid;
        @(negedge clock);
        enq_valid = 1'b0;
    endtask

    task automatic writeback(input logic v0, input logic n0, input isq_pkg::preg_t p0,
                             input logic v1, input logic n1, input isq_pkg::preg_t p1);
        {wb0_valid, wb0_need_to_wb, wb0_prd} = {v0, n0, p0};
        {wb1_valid, wb1_need_to_wb, wb1_prd} = {v1, n1, p1};
        @(negedge clock);
        wb0_valid = 1'b0;
        wb1_valid = 1'b0;
    endtask

    task automatic flush(input isq_pkg::robid_t robid);
        flush_valid = 1'b1;
        flush_robid = robid;
        @(negedge clock);
        flush_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        issue_ready = 1'b1;
        while (issue_valid && n < DRAIN_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (issue_valid) begin
            errors++;
            $display("queue did not drain within %0d cycles at %0t", DRAIN_LIMIT, $time);
        end else if (model_q.size() != 0) begin
            errors++;
            $display("mismatch at %0t: issue_valid low, model holds %0d entries", $time,
                     model_q.size());
        end
        issue_ready = 1'b0;
    endtask

    task automatic end_test(input string name, input int expected);
        tests_run++;
        if (issued - test_start != expected) begin
            errors++;
            $display("mismatch at %0t: %s issued %0d, expected %0d", $time, name,
                     issued - test_start, expected);
        end
        $display("test %0d %s done, %0d issued, %0d errors so far", tests_run, name,
                 issued - test_start, errors);
        test_start     = issued;
        accepted_start = accepted;
    endtask

    task automatic random_traffic(input int cycles);
        logic [31:0] r;
        for (int c = 0; c < cycles; c++) begin
            r = rand_bits(1);
            enq_valid = r[0];
            r = rand_bits(3);
            enq_alu_op = isq_pkg::alu_op_e'({1'b0, r[2:0]});
            r = rand_bits(32);
            enq_imm = r;
            r = rand_bits(5);
            {enq_src1_is_reg, enq_src1_state} = r[4:3];
            enq_prs1 = {3'b000, r[2:0]};   // small tag range so wakeups hit.
            r = rand_bits(5);
            {enq_src2_is_reg, enq_src2_state} = r[4:3];
            enq_prs2 = {3'b000, r[2:0]};
            r = rand_bits(3);
            enq_prd = {3'b000, r[2:0]};
            enq_robid  = next_robid;
            next_robid = next_robid + 6'd1;
            r = rand_bits(5);
            {wb0_valid, wb0_need_to_wb} = r[4:3];
            wb0_prd = {3'b000, r[2:0]};
            r = rand_bits(5);
            {wb1_valid, wb1_need_to_wb} = r[4:3];
            wb1_prd = {3'b000, r[2:0]};
            r = rand_bits(1);
            issue_ready = r[0];
            @(negedge clock);
        end
        enq_valid   = 1'b0;
        wb0_valid   = 1'b0;
        wb1_valid   = 1'b0;
        issue_ready = 1'b0;
    endtask

    // ============================================================
    // tests
    // ============================================================
    initial begin
        {rst, enq_valid, enq_src1_is_reg, enq_src2_is_reg, enq_src1_state} = 5'b10000;
        {enq_src2_state, issue_ready, wb0_valid, wb0_need_to_wb} = 4'b0000;
        {wb1_valid, wb1_need_to_wb, flush_valid} = 3'b000;
        enq_alu_op  = isq_pkg::ALU_ADD;
        enq_imm     = '0;
        {enq_prs1, enq_prs2, enq_prd, wb0_prd, wb1_prd} = '0;
        {enq_robid, flush_robid, next_robid} = '0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        for (int i = 0; i < DEPTH; i++) enq(1'b1, 6'(i), 1'b1, 1'b1, 6'(i + 8), 1'b1, 6'(i));
        if (can_alloc !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: can_alloc %b after %0d enqueues", $time, can_alloc,
                     DEPTH);
        end
        enq(1'b0, 6'd0, 1'b1, 1'b0, 6'd0, 1'b1, 6'h3F);   // dropped while full.
        drain();
        end_test("fill_drain", DEPTH);

        issue_ready = 1'b1;
        enq(1'b1, 6'd10, 1'b0, 1'b1, 6'd11, 1'b1, 6'h08);
        enq(1'b0, 6'd12, 1'b0, 1'b1, 6'd13, 1'b0, 6'h09);
        enq(1'b0, 6'd10, 1'b0, 1'b0, 6'd13, 1'b0, 6'h0A);  // no register source.
        repeat (3) @(negedge clock);
        writeback(1'b1, 1'b0, 6'd10, 1'b1, 1'b0, 6'd13);    // need_to_wb clear.
        repeat (2) @(negedge clock);
        writeback(1'b1, 1'b1, 6'd10, 1'b0, 1'b0, 6'd0);
        writeback(1'b0, 1'b0, 6'd0, 1'b1, 1'b1, 6'd13);
        drain();
        end_test("wakeup", 3);

        enq(1'b1, 6'd20, 1'b0, 1'b0, 6'd0, 1'b0, 6'h10);
        enq(1'b1, 6'd21, 1'b1, 1'b1, 6'd22, 1'b1, 6'h11);
        enq(1'b1, 6'd23, 1'b1, 1'b0, 6'd0, 1'b0, 6'h12);
        issue_ready = 1'b1;
        @(negedge clock);
        issue_ready = 1'b0;
        writeback(1'b1, 1'b1, 6'd20, 1'b0, 1'b0, 6'd0);
        drain();
        end_test("oldest_ready", 3);

        enq(1'b0, 6'd0, 1'b0, 1'b0, 6'd0, 1'b0, 6'h1C);
        enq(1'b0, 6'd0, 1'b0, 1'b0, 6'd0, 1'b0, 6'h1E);
        enq(1'b0, 6'd0, 1'b0, 1'b0, 6'd0, 1'b0, 6'h21);
        enq(1'b0, 6'd0, 1'b0, 1'b0, 6'd0, 1'b0, 6'h23);
        flush(6'h1D);   // younger ids go on both sides of the wrap.
        enq(1'b0, 6'd0, 1'b0, 1'b0, 6'd0, 1'b0, 6'h1F);
        enq(1'b0, 6'd0, 1'b0, 1'b0, 6'd0, 1'b0, 6'h20);
        flush(6'h20);   // all older, nothing goes.
        flush(6'h1F);
        drain();
        end_test("flush", 2);

        next_robid = 6'h30;
        random_traffic(400);
        for (int p = 0; p < 8; p = p + 2) writeback(1'b1, 1'b1, 6'(p), 1'b1, 1'b1, 6'(p + 1));
        drain();
        end_test("random", accepted - accepted_start);

        $display("tests %0d, checks %0d, issued %0d, errors %0d", tests_run, checks, issued,
                 errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- int_isq.f
rtl/isq_pkg.sv
rtl/isq_alloc.sv
rtl/isq_entry.sv
rtl/isq_age_select.sv
rtl/int_isq.sv
tb/int_isq_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
LINT      = --lint-only --timing
TOP       = int_isq_tb
RTL_TOP   = int_isq
FILELIST  = int_isq.f
PASS_MSG  = ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
